// ==== compile.f ====
+incdir+include
hw/hx8352_pkg.sv
hw/hx8352_bus_writer.sv
hw/hx8352_delay_timer.sv
hw/hx8352_lcd_init.sv
hw/hx8352_main_fsm.sv
hw/hx8352_ctrl_top.sv
verif/hx8352_props.sv
verif/hx8352_checker.sv
verif/tb_hx8352.sv

// ==== hw/hx8352_bus_writer.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "hx8352_cfg.svh"

module hx8352_bus_writer
	import hx8352_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic bus_step,
	input bus_req_t bus_req,
	output logic bus_done,
	output logic rs,
	output logic wr_n,
	output lcd_word_t data
);

	localparam logic [3:0] LOW_LAST = 4'(`HX_WR_LOW_CYCLES - 1);
	localparam logic [3:0] HIGH_LAST = 4'(`HX_WR_HIGH_CYCLES - 1);

	bus_state_t state;
	logic [3:0] phase;

	// last cycle of the high phase
	assign bus_done = (state == BW_HIGH) && (phase == HIGH_LAST);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= BW_IDLE;
			phase <= '0;
			wr_n <= 1'b1;
		end else begin
			case (state)
				BW_IDLE: begin
					if (bus_step) begin
						state <= BW_LOW;
						phase <= '0;
						wr_n <= 1'b0;
					end
				end
				BW_LOW: begin
					if (phase == LOW_LAST) begin
						// panel latches on this rising edge
						state <= BW_HIGH;
						phase <= '0;
						wr_n <= 1'b1;
					end else begin
						phase <= phase + 4'd1;
					end
				end
				BW_HIGH: begin
					if (phase == HIGH_LAST)
						state <= BW_IDLE;
					else
						phase <= phase + 4'd1;
				end
				default: state <= BW_IDLE;
			endcase
		end
	end

	// rs and data held for the whole cycle
	always_ff @(posedge clk) begin
		if (state == BW_IDLE && bus_step) begin
			rs <= bus_req.rs;
			data <= bus_req.word;
		end
	end

endmodule

`default_nettype wire

// ==== hw/hx8352_ctrl_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module hx8352_ctrl_top
	import hx8352_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic pixel_step,
	input lcd_word_t pixel_data,
	output lcd_pins_t lcd,
	output logic init_done,
	output logic pixel_ready
);

	bus_req_t bus_req;
	logic bus_step;
	logic bus_done;
	delay_t delay_value;
	logic delay_step;
	logic delay_done;
	logic cs_n;
	logic rst_n;
	logic rs;
	logic wr_n;
	lcd_word_t data;

	hx8352_main_fsm u_main_fsm (
		.clk(clk),
		.rst(rst),
		.bus_done(bus_done),
		.delay_done(delay_done),
		.pixel_step(pixel_step),
		.pixel_data(pixel_data),
		.init_done(init_done),
		.bus_step(bus_step),
		.delay_step(delay_step),
		.cs_n(cs_n),
		.rst_n(rst_n),
		.pixel_ready(pixel_ready),
		.bus_req(bus_req),
		.delay_value(delay_value)
	);

	hx8352_bus_writer u_bus_writer (
		.clk(clk),
		.rst(rst),
		.bus_step(bus_step),
		.bus_req(bus_req),
		.bus_done(bus_done),
		.rs(rs),
		.wr_n(wr_n),
		.data(data)
	);

	hx8352_delay_timer u_delay_timer (
		.clk(clk),
		.rst(rst),
		.delay_step(delay_step),
		.delay_value(delay_value),
		.delay_done(delay_done)
	);

	assign lcd = '{cs_n: cs_n, rst_n: rst_n, rs: rs, wr_n: wr_n, data: data};

endmodule

`default_nettype wire

// ==== hw/hx8352_delay_timer.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "hx8352_cfg.svh"

module hx8352_delay_timer
	import hx8352_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic delay_step,
	input delay_t delay_value,
	output logic delay_done
);

	localparam int PRE_W = $clog2(`HX_DELAY_PRESCALE + 1);
	localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(`HX_DELAY_PRESCALE - 1);

	logic active;
	logic [PRE_W-1:0] pre;
	delay_t ticks;

	// fires on the end of the last tick, zero counts as one tick
	assign delay_done = active && (pre == '0) && (ticks <= delay_t'(1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			active <= 1'b0;
			pre <= '0;
			ticks <= '0;
		end else if (delay_step) begin
			// restart even if a count is running
			active <= 1'b1;
			pre <= PRE_LAST;
			ticks <= delay_value;
		end else if (active) begin
			if (pre == '0) begin
				pre <= PRE_LAST;
				if (ticks <= delay_t'(1))
					active <= 1'b0;
				else
					ticks <= ticks - delay_t'(1);
			end else begin
				pre <= pre - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/hx8352_lcd_init.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "hx8352_cfg.svh"

module hx8352_lcd_init
	import hx8352_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic step,
	input logic bus_done,
	input logic delay_done,
	output logic bus_step,
	output logic delay_step,
	output logic done,
	output bus_req_t bus_req,
	output delay_t delay_value
);

	localparam int PC_W = $clog2(`HX_INIT_LEN);

	function automatic init_entry_t cmd_entry(input lcd_cmd_t c);
		return '{kind: INIT_CMD, word: {8'h00, c}};
	endfunction

	function automatic init_entry_t data_entry(input lcd_word_t w);
		return '{kind: INIT_DATA, word: w};
	endfunction

	function automatic init_entry_t delay_entry(input delay_t d);
		return '{kind: INIT_DELAY, word: d};
	endfunction

	// panel power-up table
	function automatic init_entry_t rom_entry(input logic [PC_W-1:0] idx);
		init_entry_t e;
		case (idx)
			0: e = cmd_entry(8'h83);
			1: e = data_entry(16'h0002);
			2: e = delay_entry(16'd5);
			3: e = cmd_entry(8'h85);
			4: e = data_entry(16'h0003);
			5: e = cmd_entry(8'h8B);
			6: e = data_entry(16'h0001);
			7: e = cmd_entry(8'h8C);
			8: e = data_entry(16'h0093);
			9: e = cmd_entry(8'h91);
			10: e = data_entry(16'h0001);
			11: e = delay_entry(16'd10);
			// display on, gate first then source
			12: e = cmd_entry(8'h28);
			13: e = data_entry(16'h0038);
			14: e = delay_entry(16'd10);
			15: e = cmd_entry(8'h28);
			16: e = data_entry(16'h003C);
			default: e = '{kind: INIT_END, word: '0};
		endcase
		return e;
	endfunction

	init_state_t state;
	logic [PC_W-1:0] pc;
	init_entry_t entry;

	assign entry = rom_entry(pc);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= IS_IDLE;
			pc <= '0;
			bus_step <= 1'b0;
			delay_step <= 1'b0;
			done <= 1'b0;
		end else begin
			bus_step <= 1'b0;
			delay_step <= 1'b0;
			case (state)
				IS_IDLE: begin
					if (step) begin
						pc <= '0;
						state <= IS_FETCH;
					end
				end
				IS_FETCH: begin
					case (entry.kind)
						INIT_CMD, INIT_DATA: begin
							bus_step <= 1'b1;
							state <= IS_BUS_WAIT;
						end
						INIT_DELAY: begin
							delay_step <= 1'b1;
							state <= IS_DELAY_WAIT;
						end
						default: begin
							done <= 1'b1;
							state <= IS_DONE;
						end
					endcase
				end
				IS_BUS_WAIT: begin
					if (bus_done) begin
						pc <= pc + 1'b1;
						state <= IS_FETCH;
					end
				end
				IS_DELAY_WAIT: begin
					if (delay_done) begin
						pc <= pc + 1'b1;
						state <= IS_FETCH;
					end
				end
				// one pass only
				IS_DONE: state <= IS_DONE;
				default: state <= IS_IDLE;
			endcase
		end
	end

	// request payload, valid alongside the step pulses
	always_ff @(posedge clk) begin
		if (state == IS_FETCH) begin
			bus_req.rs <= (entry.kind == INIT_DATA);
			bus_req.word <= entry.word;
			delay_value <= delay_t'(entry.word);
		end
	end

endmodule

`default_nettype wire

// ==== hw/hx8352_main_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "hx8352_cfg.svh"

module hx8352_main_fsm
	import hx8352_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic bus_done,
	input logic delay_done,
	input logic pixel_step,
	input lcd_word_t pixel_data,
	output logic init_done,
	output logic bus_step,
	output logic delay_step,
	output logic cs_n,
	output logic rst_n,
	output logic pixel_ready,
	output bus_req_t bus_req,
	output delay_t delay_value
);

	localparam lcd_cmd_t MEM_WRITE = `HX_CMD_MEM_WRITE;

	main_state_t state;
	logic init_step;
	logic init_bus_step;
	logic init_delay_step;
	bus_req_t init_bus_req;
	delay_t init_delay_value;
	logic bus_step_q;
	logic delay_step_q;
	bus_req_t bus_req_q;
	delay_t delay_value_q;

	hx8352_lcd_init u_lcd_init (
		.clk(clk),
		.rst(rst),
		.step(init_step),
		.bus_done(bus_done),
		.delay_done(delay_done),
		.bus_step(init_bus_step),
		.delay_step(init_delay_step),
		.done(init_done),
		.bus_req(init_bus_req),
		.delay_value(init_delay_value)
	);

	assign pixel_ready = (state == MS_PIX_WAIT);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= MS_RESET;
			init_step <= 1'b0;
			bus_step_q <= 1'b0;
			delay_step_q <= 1'b0;
			cs_n <= 1'b1;
			rst_n <= 1'b1;
		end else begin
			case (state)
				MS_RESET: begin
					rst_n <= 1'b0;
					delay_step_q <= 1'b1;
					state <= MS_RST_LOW;
				end
				MS_RST_LOW: begin
					delay_step_q <= 1'b0;
					if (delay_done) begin
						rst_n <= 1'b1;
						delay_step_q <= 1'b1;
						state <= MS_RST_WAIT;
					end
				end
				MS_RST_WAIT: begin
					delay_step_q <= 1'b0;
					if (delay_done) begin
						cs_n <= 1'b0;
						init_step <= 1'b1;
						state <= MS_INIT;
					end
				end
				MS_INIT: begin
					init_step <= 1'b0;
					if (init_done)
						state <= MS_IDLE;
				end
				// short deselect between init and the pixel stream
				MS_IDLE: begin
					cs_n <= 1'b1;
					state <= MS_PIX_START;
				end
				MS_PIX_START: begin
					cs_n <= 1'b0;
					state <= MS_CMD;
				end
				MS_CMD: begin
					bus_step_q <= 1'b1;
					state <= MS_CMD_WAIT;
				end
				MS_CMD_WAIT: begin
					bus_step_q <= 1'b0;
					if (bus_done)
						state <= MS_PIX_WAIT;
				end
				MS_PIX_WAIT: begin
					if (pixel_step) begin
						bus_step_q <= 1'b1;
						state <= MS_PIX_BUSY;
					end
				end
				MS_PIX_BUSY: begin
					bus_step_q <= 1'b0;
					if (bus_done)
						state <= MS_PIX_WAIT;
				end
				default: state <= MS_RESET;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			MS_RESET: delay_value_q <= delay_t'(`HX_RST_LOW_TICKS);
			MS_RST_LOW: begin
				if (delay_done)
					delay_value_q <= delay_t'(`HX_RST_WAIT_TICKS);
			end
			MS_CMD: bus_req_q <= '{rs: 1'b0, word: {8'h00, MEM_WRITE}};
			MS_PIX_WAIT: begin
				if (pixel_step)
					bus_req_q <= '{rs: 1'b1, word: pixel_data};
			end
			default: ;
		endcase
	end

	// sequencer owns the bus and the timer only during init
	always_comb begin
		case (state)
			MS_INIT: begin
				bus_step = init_bus_step;
				bus_req = init_bus_req;
				delay_step = init_delay_step;
				delay_value = init_delay_value;
			end
			default: begin
				bus_step = bus_step_q;
				bus_req = bus_req_q;
				delay_step = delay_step_q;
				delay_value = delay_value_q;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/hx8352_pkg.sv ====
`default_nettype none

package hx8352_pkg;

	typedef logic [15:0] lcd_word_t;
	typedef logic [7:0] lcd_cmd_t;
	typedef logic [15:0] delay_t;

	// one request to the bus writer, rs low selects a command
	typedef struct packed {
		logic rs;
		lcd_word_t word;
	} bus_req_t;

	// panel pins, strobes are active low
	typedef struct packed {
		logic cs_n;
		logic rst_n;
		logic rs;
		logic wr_n;
		lcd_word_t data;
	} lcd_pins_t;

	typedef enum logic [1:0] {
		INIT_CMD = 2'd0,
		INIT_DATA = 2'd1,
		INIT_DELAY = 2'd2,
		INIT_END = 2'd3
	} init_kind_t;

	// for INIT_DELAY the word holds the tick count
	typedef struct packed {
		init_kind_t kind;
		lcd_word_t word;
	} init_entry_t;

	typedef enum logic [3:0] {
		MS_RESET,
		MS_RST_LOW,
		MS_RST_WAIT,
		MS_INIT,
		MS_IDLE,
		MS_PIX_START,
		MS_CMD,
		MS_CMD_WAIT,
		MS_PIX_WAIT,
		MS_PIX_BUSY
	} main_state_t;

	typedef enum logic [2:0] {
		IS_IDLE,
		IS_FETCH,
		IS_BUS_WAIT,
		IS_DELAY_WAIT,
		IS_DONE
	} init_state_t;

	typedef enum logic [1:0] {
		BW_IDLE,
		BW_LOW,
		BW_HIGH
	} bus_state_t;

endpackage

`default_nettype wire

// ==== include/hx8352_cfg.svh ====
`ifndef HX8352_CFG_SVH
`define HX8352_CFG_SVH

// write strobe shape in clock cycles
`define HX_WR_LOW_CYCLES 2
`define HX_WR_HIGH_CYCLES 2

// clock cycles per delay tick
`define HX_DELAY_PRESCALE 4

// panel reset pulse and settle time, in ticks
`define HX_RST_LOW_TICKS 50
`define HX_RST_WAIT_TICKS 60

// memory write command, opens the pixel stream
`define HX_CMD_MEM_WRITE 8'h22

// entries in the init table, INIT_END included
`define HX_INIT_LEN 18

`endif

// ==== run.sh ====
#!/bin/sh
# build and run the HX8352 controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_hx8352 \
	-Mdir obj_dir -o sim_hx8352
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

# let every assertion failure print instead of stopping at the first
out=$(./obj_dir/sim_hx8352 +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "All tests passed"; then
	exit 0
fi
exit 1

// ==== verif/hx8352_checker.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "hx8352_cfg.svh"

module hx8352_checker
	import hx8352_pkg::*;
(
	input logic clk,
	input logic rst,
	input lcd_pins_t lcd,
	input logic init_done,
	input logic pixel_ready,
	input logic pixel_step,
	output int errors,
	output int writes
);

	localparam int unsigned PRESCALE = `HX_DELAY_PRESCALE;
	localparam int unsigned RST_LOW_CYCLES = `HX_RST_LOW_TICKS * PRESCALE;
	localparam int unsigned RST_WAIT_CYCLES = `HX_RST_WAIT_TICKS * PRESCALE;
	localparam int unsigned WR_LOW = `HX_WR_LOW_CYCLES;
	localparam int unsigned WR_HIGH = `HX_WR_HIGH_CYCLES;
	localparam lcd_word_t MEM_WRITE_WORD = {8'h00, `HX_CMD_MEM_WRITE};

	// which kind of write the bus should carry next
	localparam int PH_INIT = 0;
	localparam int PH_CMD = 1;
	localparam int PH_PIXEL = 2;

	lcd_word_t pixel_q[$];
	int unsigned cycle;
	int unsigned rst_low_count;
	int unsigned rst_rise_cycle;
	int unsigned last_write_cycle;
	int unsigned low_count;
	int unsigned high_count;
	int tbl_idx;
	int phase;
	int cmd_writes;
	int pixel_writes;
	logic rst_rose;
	logic cs_fell;
	logic pix_pending;
	logic prev_wr_n;
	logic prev_rst_n;
	logic prev_cs_n;
	logic prev_init_done;

	// expected power-up table
	function automatic init_entry_t model_entry(input int idx);
		init_entry_t e;
		case (idx)
			0: e = '{INIT_CMD, 16'h0083};
			1: e = '{INIT_DATA, 16'h0002};
			2: e = '{INIT_DELAY, 16'd5};
			3: e = '{INIT_CMD, 16'h0085};
			4: e = '{INIT_DATA, 16'h0003};
			5: e = '{INIT_CMD, 16'h008B};
			6: e = '{INIT_DATA, 16'h0001};
			7: e = '{INIT_CMD, 16'h008C};
			8: e = '{INIT_DATA, 16'h0093};
			9: e = '{INIT_CMD, 16'h0091};
			10: e = '{INIT_DATA, 16'h0001};
			11: e = '{INIT_DELAY, 16'd10};
			12: e = '{INIT_CMD, 16'h0028};
			13: e = '{INIT_DATA, 16'h0038};
			14: e = '{INIT_DELAY, 16'd10};
			15: e = '{INIT_CMD, 16'h0028};
			16: e = '{INIT_DATA, 16'h003C};
			default: e = '{INIT_END, 16'h0000};
		endcase
		return e;
	endfunction

	task automatic flag_value(input string sig, input lcd_word_t got, input lcd_word_t exp);
		errors++;
		$display("error: %s got 0x%h expected 0x%h at cycle %0d", sig, got, exp, cycle);
	endtask

	task automatic flag_problem(input string what);
		errors++;
		$display("check failed at cycle %0d: %s", cycle, what);
	endtask

	task automatic expect_pixel(input lcd_word_t w);
		pixel_q.push_back(w);
	endtask

	// one completed write, seen at the rising edge of wr_n
	task automatic check_write();
		init_entry_t exp_e;
		int unsigned min_gap;
		lcd_word_t exp_word;
		min_gap = 0;
		if (phase == PH_INIT) begin
			exp_e = model_entry(tbl_idx);
			// delays between two writes add up to the minimum spacing
			while (exp_e.kind == INIT_DELAY) begin
				min_gap = min_gap + 32'(exp_e.word) * PRESCALE;
				tbl_idx++;
				exp_e = model_entry(tbl_idx);
			end
			if (exp_e.kind == INIT_END)
				phase = PH_CMD;
		end
		case (phase)
			PH_INIT: begin
				if (init_done)
					flag_problem("init_done high before the init table finished");
				if (cycle - last_write_cycle < min_gap)
					flag_problem($sformatf("writes only %0d cycles apart across a %0d cycle delay",
						cycle - last_write_cycle, min_gap));
				if (lcd.rs !== (exp_e.kind == INIT_DATA))
					flag_value("lcd.rs", 16'(lcd.rs), 16'(exp_e.kind == INIT_DATA));
				if (lcd.data !== exp_e.word)
					flag_value("lcd.data", lcd.data, exp_e.word);
				tbl_idx++;
			end
			PH_CMD: begin
				if (!init_done)
					flag_problem("memory write command sent before init_done");
				if (lcd.rs !== 1'b0)
					flag_value("lcd.rs", 16'(lcd.rs), 16'h0000);
				if (lcd.data !== MEM_WRITE_WORD)
					flag_value("lcd.data", lcd.data, MEM_WRITE_WORD);
				cmd_writes++;
				phase = PH_PIXEL;
			end
			default: begin
				pixel_writes++;
				pix_pending = 1'b0;
				if (lcd.rs !== 1'b1)
					flag_value("lcd.rs", 16'(lcd.rs), 16'h0001);
				if (pixel_q.size() == 0) begin
					flag_problem("pixel write on the bus with no pixel sent");
				end else begin
					exp_word = pixel_q.pop_front();
					if (lcd.data !== exp_word)
						flag_value("lcd.data", lcd.data, exp_word);
				end
			end
		endcase
		last_write_cycle = cycle;
	endtask

	always @(posedge clk) begin
		if (rst) begin
			errors = 0;
			writes = 0;
			cycle = 0;
			rst_low_count = 0;
			rst_rise_cycle = 0;
			last_write_cycle = 0;
			low_count = 0;
			high_count = 0;
			tbl_idx = 0;
			phase = PH_INIT;
			cmd_writes = 0;
			pixel_writes = 0;
			rst_rose = 1'b0;
			cs_fell = 1'b0;
			pix_pending = 1'b0;
			prev_wr_n = 1'b1;
			prev_rst_n = 1'b1;
			prev_cs_n = 1'b1;
			prev_init_done = 1'b0;
		end else begin
			cycle++;
			// panel reset pulse
			if (lcd.rst_n === 1'b0) begin
				rst_low_count++;
				if (lcd.cs_n !== 1'b1)
					flag_problem("cs_n low while the panel is held in reset");
			end
			if (lcd.rst_n === 1'b1 && prev_rst_n === 1'b0) begin
				rst_rose = 1'b1;
				rst_rise_cycle = cycle;
				if (rst_low_count + 2 < RST_LOW_CYCLES || rst_low_count > RST_LOW_CYCLES + 2)
					flag_problem($sformatf("panel reset low for %0d cycles instead of %0d",
						rst_low_count, RST_LOW_CYCLES));
			end
			if (lcd.cs_n === 1'b0 && prev_cs_n === 1'b1 && !cs_fell) begin
				cs_fell = 1'b1;
				if (!rst_rose || cycle - rst_rise_cycle < RST_WAIT_CYCLES)
					flag_problem("cs_n dropped before the reset wait ended");
			end
			// strobe shape
			if (lcd.wr_n === 1'b0) begin
				if (lcd.cs_n !== 1'b0)
					flag_problem("wr_n low while cs_n is high");
				if (prev_wr_n === 1'b1) begin
					if (writes > 0 && high_count < WR_HIGH)
						flag_problem($sformatf("wr_n high for only %0d cycles", high_count));
					low_count = 1;
				end else begin
					low_count++;
				end
			end else if (prev_wr_n === 1'b0) begin
				if (low_count != WR_LOW)
					flag_problem($sformatf("wr_n low for %0d cycles instead of %0d",
						low_count, WR_LOW));
				high_count = 1;
				writes++;
				check_write();
			end else begin
				high_count++;
			end
			// pixel flow control
			if (pix_pending && pixel_ready)
				flag_problem("pixel_ready high again before the pixel was written");
			if (pixel_step) begin
				if (!pixel_ready)
					flag_problem("pixel_step while pixel_ready is low");
				pix_pending = 1'b1;
			end
			if (pixel_ready && !init_done)
				flag_problem("pixel_ready high before init_done");
			if (prev_init_done && !init_done)
				flag_problem("init_done fell after rising");
			prev_wr_n = lcd.wr_n;
			prev_rst_n = lcd.rst_n;
			prev_cs_n = lcd.cs_n;
			prev_init_done = init_done;
		end
	end

	// end of run bookkeeping, returns the number of problems found
	function automatic int end_problems(input int sent);
		int n;
		n = 0;
		if (!rst_rose) begin
			$display("check failed: panel reset pulse never completed");
			n++;
		end
		if (cmd_writes != 1) begin
			$display("check failed: %0d memory write commands seen instead of one", cmd_writes);
			n++;
		end
		if (pixel_writes != sent) begin
			$display("check failed: %0d pixel writes seen for %0d pixels sent",
				pixel_writes, sent);
			n++;
		end
		if (pixel_q.size() != 0) begin
			$display("check failed: %0d sent pixels never reached the bus", pixel_q.size());
			n++;
		end
		return n;
	endfunction

endmodule

`default_nettype wire

// ==== verif/hx8352_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module hx8352_props
	import hx8352_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic pixel_step,
	input logic pixel_ready,
	input logic init_done,
	input lcd_pins_t lcd
);

	// a pixel is only taken while the FSM waits for one
	a_step_needs_ready: assert property (@(posedge clk) disable iff (rst)
		pixel_step |-> pixel_ready)
		else $error("pixel_step arrived while pixel_ready was low");

	a_ready_drops: assert property (@(posedge clk) disable iff (rst)
		pixel_step |=> !pixel_ready)
		else $error("pixel_ready stayed high after pixel_step");

	a_write_selected: assert property (@(posedge clk) disable iff (rst)
		!lcd.wr_n |-> !lcd.cs_n)
		else $error("wr_n low while cs_n high");

	// panel deselected through its reset pulse
	a_reset_deselected: assert property (@(posedge clk) disable iff (rst)
		!lcd.rst_n |-> lcd.cs_n)
		else $error("cs_n low during panel reset");

	// pixel stream only opens once the init table has been played
	a_ready_after_init: assert property (@(posedge clk) disable iff (rst)
		pixel_ready |-> init_done)
		else $error("pixel_ready high before init_done");

endmodule

bind hx8352_ctrl_top hx8352_props u_props (
	.clk(clk),
	.rst(rst),
	.pixel_step(pixel_step),
	.pixel_ready(pixel_ready),
	.init_done(init_done),
	.lcd(lcd)
);

`default_nettype wire

// ==== verif/tb_hx8352.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_hx8352;
	import hx8352_pkg::*;

	localparam int PIXELS = 200;
	localparam int RST_CYCLES = 16;
	localparam logic [31:0] SEED = 32'h6376_d4c7;
	// reset and delays about 650, init writes about 200, pixels about 12 each
	localparam int unsigned RUN_ESTIMATE = 650 + 200 + PIXELS * 12;
	localparam int unsigned TIMEOUT_CYCLES = RUN_ESTIMATE * 6;

	logic clk;
	logic rst;
	logic pixel_step;
	lcd_word_t pixel_data;
	lcd_pins_t lcd;
	logic init_done;
	logic pixel_ready;
	int errors;
	int writes;
	int sent;
	int unsigned cycles = 0;

	hx8352_ctrl_top u_hx8352_ctrl_top (
		.clk(clk),
		.rst(rst),
		.pixel_step(pixel_step),
		.pixel_data(pixel_data),
		.lcd(lcd),
		.init_done(init_done),
		.pixel_ready(pixel_ready)
	);

	hx8352_checker u_checker (
		.clk(clk),
		.rst(rst),
		.lcd(lcd),
		.init_done(init_done),
		.pixel_ready(pixel_ready),
		.pixel_step(pixel_step),
		.errors(errors),
		.writes(writes)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		int unsigned gap;
		int total;
		rst = 1'b1;
		pixel_step = 1'b0;
		pixel_data = '0;
		sent = 0;
		void'($urandom(SEED));
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// one pixel per ready window, after a random pause
		while (sent < PIXELS) begin
			while (!pixel_ready)
				@(negedge clk);
			gap = $urandom_range(5, 0);
			repeat (gap) @(negedge clk);
			pixel_data = 16'($urandom);
			pixel_step = 1'b1;
			u_checker.expect_pixel(pixel_data);
			sent++;
			@(negedge clk);
			pixel_step = 1'b0;
		end
		// ready again once the last write is on the panel
		while (!pixel_ready)
			@(negedge clk);
		repeat (4) @(negedge clk);
		total = errors + u_checker.end_problems(PIXELS);
		$display("closing: %0d pixels sent, %0d bus writes, %0d errors", sent, writes, total);
		if (total == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run not finished after %0d cycles", TIMEOUT_CYCLES);
			$display("closing: %0d pixels sent, %0d bus writes, %0d errors, 1 timeout",
				sent, writes, errors);
			$display("Some tests failed");
			$finish;
		end
	end

endmodule

`default_nettype wire
